// ==== merge_defines.svh ====
/*
 * packet merger build constants
 * channel count, payload width, buffer depth and the
 * credit limits on both sides of the merger
 */

`ifndef MERGE_DEFINES_SVH
`define MERGE_DEFINES_SVH

// number of input channels
`define MERGE_PORTS 4

// payload data bits per flit
`define MERGE_DATA_W 16

// flits per input buffer, also each sender's starting credits
`define MERGE_BUF_DEPTH 4

// credits granted by the downstream receiver after reset
`define MERGE_OUT_CREDITS 3

// width of the credit counters
`define MERGE_CNT_W 3

`endif

// ==== merge_pkg.sv ====
/*
 * packet merger types
 * payload, flit, port vector and credit counter types shared by
 * the buffers, the arbiter, the credit tracker and the top level
 */

`include "merge_defines.svh"

package merge_pkg;

   // operation selector for the prefix scan
   typedef enum logic [1:0]
   {
      scan_xor = 2'd0,
      scan_and = 2'd1,
      scan_or  = 2'd2
   } scan_op_e;

   // what a sender drives and a buffer stores
   typedef struct packed
   {
      logic [`MERGE_DATA_W-1:0] data;
      logic                     last;   // end of packet
   } payload_t;

   // channel index
   typedef logic [$clog2(`MERGE_PORTS)-1:0] port_idx_t;

   // merged output flit, src stamped from the grant
   typedef struct packed
   {
      port_idx_t src;
      payload_t  payload;
   } flit_t;

   // one bit per channel
   typedef logic [`MERGE_PORTS-1:0] port_vec_t;

   typedef logic [`MERGE_CNT_W-1:0] credit_cnt_t;

endpackage

// ==== prefix_scan.sv ====
/*
 * parallel prefix scan
 * inclusive xor / and / or prefix over the input bits, from the high bit
 * down or from the low bit up, built as a log-depth Kogge-Stone tree
 */

`timescale 1ns/1ps

module prefix_scan
#(
   parameter int                   width_p    = 4,
   parameter merge_pkg::scan_op_e  op_p       = merge_pkg::scan_or,
   parameter bit                   lo_to_hi_p = 1'b0
)
(
   input  logic [width_p-1:0] i,
   output logic [width_p-1:0] o
);

   localparam int levels_lp = $clog2(width_p);

   // identity of the operation, only and has a one
   localparam logic fill_bit_lp = (op_p == merge_pkg::scan_and);

   // row 0 is the (maybe reversed) input, the last row is the result
   logic [levels_lp:0][width_p-1:0] t;
   logic [width_p-1:0]              fill;

   assign fill = {width_p{fill_bit_lp}};

   // only the three scan operations are defined
   if (!(op_p inside {merge_pkg::scan_xor, merge_pkg::scan_and, merge_pkg::scan_or}))
   begin : g_bad_op
      $error("prefix_scan: op_p must select xor, and or or");
   end

   // the tree always scans high to low, so reverse for lo_to_hi
   if (lo_to_hi_p)
   begin : g_rev_in
      for (genvar k = 0; k < width_p; k++)
      begin : g_bit
         assign t[0][k] = i[width_p-1-k];
      end
   end
   else
   begin : g_dir_in
      assign t[0] = i;
   end

   if ((op_p == merge_pkg::scan_and) && (width_p > 1) && (width_p <= 4))
   begin : g_flat_and
      // small and-scans as one reduction per bit
      for (genvar k = 0; k < width_p; k++)
      begin : g_bit
         assign t[levels_lp][k] = &t[0][width_p-1:k];
      end
      // middle rows carry no meaning here
      for (genvar j = 1; j < levels_lp; j++)
      begin : g_pass
         assign t[j] = t[0];
      end
   end
   else
   begin : g_tree
      for (genvar j = 0; j < levels_lp; j++)
      begin : g_row
         logic [width_p-1:0] shifted;

         // distance doubles each row, vacated high bits get the identity
         assign shifted = width_p'({fill, t[j]} >> (1 << j));

         if (op_p == merge_pkg::scan_xor)
         begin : g_xor
            assign t[j+1] = t[j] ^ shifted;
         end
         else if (op_p == merge_pkg::scan_and)
         begin : g_and
            assign t[j+1] = t[j] & shifted;
         end
         else
         begin : g_or
            assign t[j+1] = t[j] | shifted;
         end
      end
   end

   // undo the input reversal
   if (lo_to_hi_p)
   begin : g_rev_out
      for (genvar k = 0; k < width_p; k++)
      begin : g_bit
         assign o[k] = t[levels_lp][width_p-1-k];
      end
   end
   else
   begin : g_dir_out
      assign o = t[levels_lp];
   end

endmodule

// ==== flit_buffer.sv ====
/*
 * per-channel flit buffer
 * circular FIFO holding up to depth_p payloads; every pop returns one
 * credit to the sender on the following cycle
 */

`timescale 1ns/1ps

module flit_buffer
#(
   parameter type payload_type = logic [7:0],
   parameter int  depth_p      = 4
)
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        push,
   input  payload_type push_data,
   input  logic        pop,
   output payload_type head,
   output logic        not_empty,
   output logic        credit
);

   localparam int ptr_w_lp = (depth_p > 1) ? $clog2(depth_p) : 1;
   localparam int cnt_w_lp = $clog2(depth_p + 1);

   payload_type         mem [depth_p];
   logic [ptr_w_lp-1:0] wr_ptr;
   logic [ptr_w_lp-1:0] rd_ptr;
   logic [cnt_w_lp-1:0] count;
   logic                full;

   assign full      = (count == cnt_w_lp'(depth_p));
   assign not_empty = (count != '0);

   // oldest flit, read straight from storage
   assign head = mem[rd_ptr];

   // storage, written at the tail
   always_ff @(posedge clk)
   begin
      if (push)
      begin
         mem[wr_ptr] <= push_data;
      end
   end

   // pointers and occupancy
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
         begin
            // explicit wrap, depth need not be a power of two
            wr_ptr <= (wr_ptr == ptr_w_lp'(depth_p - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop)
         begin
            rd_ptr <= (rd_ptr == ptr_w_lp'(depth_p - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // one credit back to the sender per freed slot, a cycle after the pop
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         credit <= 1'b0;
      end
      else
      begin
         credit <= pop;
      end
   end

   // a sender with correct credit accounting can never hit a full buffer
   a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
      !(push && full));

   // the arbiter only pops buffers that raised a request
   a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n)
      !(pop && !not_empty));

endmodule

// ==== rr_arbiter.sv ====
/*
 * round-robin packet arbiter
 * picks the first requester at or above the pointer with two or-scans,
 * holds the grant until the last flit of the packet and pops only while
 * the output has credit
 */

`timescale 1ns/1ps

`include "merge_defines.svh"

module rr_arbiter
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  merge_pkg::port_vec_t req,
   input  merge_pkg::port_vec_t head_last,
   input  logic                 can_send,
   output merge_pkg::port_vec_t pop,
   output logic                 send,
   output merge_pkg::port_idx_t grant_idx
);

   localparam int ports_lp = `MERGE_PORTS;

   merge_pkg::port_idx_t ptr;
   merge_pkg::port_idx_t held_idx;
   merge_pkg::port_idx_t pick_idx;
   merge_pkg::port_idx_t winner;
   logic                 held;

   merge_pkg::port_vec_t mask;
   merge_pkg::port_vec_t req_masked;
   merge_pkg::port_vec_t scan_masked;
   merge_pkg::port_vec_t scan_all;
   merge_pkg::port_vec_t first_masked;
   merge_pkg::port_vec_t first_all;
   merge_pkg::port_vec_t pick;

   // thermometer of ones from the pointer upwards
   always_comb
   begin
      for (int k = 0; k < ports_lp; k++)
      begin
         mask[k] = (k >= int'(ptr));
      end
   end

   assign req_masked = req & mask;

   // o[k] is the or of bits k down to 0
   prefix_scan
   #(
      .width_p    (ports_lp),
      .op_p       (merge_pkg::scan_or),
      .lo_to_hi_p (1'b1)
   )
   i_scan_masked
   (
      .i (req_masked),
      .o (scan_masked)
   );

   prefix_scan
   #(
      .width_p    (ports_lp),
      .op_p       (merge_pkg::scan_or),
      .lo_to_hi_p (1'b1)
   )
   i_scan_all
   (
      .i (req),
      .o (scan_all)
   );

   // first set bit is where the running or turns on
   assign first_masked = scan_masked & ~(scan_masked << 1);
   assign first_all    = scan_all & ~(scan_all << 1);

   // wrap to the lowest requester when nothing sits at or above the pointer
   assign pick = (|req_masked) ? first_masked : first_all;

   // one-hot to index
   always_comb
   begin
      pick_idx = '0;
      for (int k = 0; k < ports_lp; k++)
      begin
         if (pick[k])
         begin
            pick_idx = merge_pkg::port_idx_t'(k);
         end
      end
   end

   // a packet in progress keeps its channel even while that buffer is empty
   assign winner    = held ? held_idx : pick_idx;
   assign send      = can_send && (held ? req[held_idx] : |req);
   assign pop       = send ? (merge_pkg::port_vec_t'(1) << winner) : '0;
   assign grant_idx = winner;

   // grant hold and pointer update
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         ptr      <= '0;
         held     <= 1'b0;
         held_idx <= '0;
      end
      else if (send)
      begin
         if (head_last[winner])
         begin
            // packet done so the next search starts one past the winner
            held <= 1'b0;
            ptr  <= (winner == merge_pkg::port_idx_t'(ports_lp - 1)) ? '0 : winner + 1'b1;
         end
         else
         begin
            held     <= 1'b1;
            held_idx <= winner;
         end
      end
   end

   // at most one pop and only to a buffer that holds a flit
   a_pop_onehot : assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(pop) && ((pop & ~req) == '0));

endmodule

// ==== credit_tracker.sv ====
/*
 * output credit tracker
 * counts the downstream receiver's free slots and allows a send
 * only while at least one credit is left
 */

`timescale 1ns/1ps

`include "merge_defines.svh"

module credit_tracker
(
   input  logic clk,
   input  logic rst_n,
   input  logic send,
   input  logic out_credit,
   output logic can_send
);

   localparam merge_pkg::credit_cnt_t max_lp = merge_pkg::credit_cnt_t'(`MERGE_OUT_CREDITS);

   merge_pkg::credit_cnt_t cnt;

   // spend on send, refill on out_credit, both together cancel
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         cnt <= max_lp;
      end
      else
      begin
         case ({send, out_credit})
            2'b10:   cnt <= cnt - 1'b1;
            2'b01:   cnt <= cnt + 1'b1;
            default: cnt <= cnt;
         endcase
      end
   end

   // a returned credit is usable the cycle after it arrives
   assign can_send = (cnt != '0);

   // receiver never returns more slots than it was given
   a_no_excess : assert property (@(posedge clk) disable iff (!rst_n)
      (out_credit && !send) |-> (cnt < max_lp));

   // arbiter must respect can_send
   a_no_overdraw : assert property (@(posedge clk) disable iff (!rst_n)
      send |-> (cnt != '0));

endmodule

// ==== packet_merger.sv ====
/*
 * credit-based packet merger
 * four buffered input channels merged onto one output by a
 * round-robin packet arbiter, with credits on both sides
 */

`timescale 1ns/1ps

`include "merge_defines.svh"

module packet_merger
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  merge_pkg::port_vec_t in_valid,
   input  merge_pkg::payload_t  in_payload [`MERGE_PORTS],
   output merge_pkg::port_vec_t in_credit,
   output logic                 out_valid,
   output merge_pkg::flit_t     out_flit,
   input  logic                 out_credit
);

   merge_pkg::payload_t  head [`MERGE_PORTS];
   merge_pkg::port_vec_t req;
   merge_pkg::port_vec_t head_last;
   merge_pkg::port_vec_t pop;
   merge_pkg::port_idx_t grant_idx;
   logic                 send;
   logic                 can_send;

   // one buffer per input channel
   for (genvar c = 0; c < `MERGE_PORTS; c++)
   begin : g_chan
      flit_buffer
      #(
         .payload_type (merge_pkg::payload_t),
         .depth_p      (`MERGE_BUF_DEPTH)
      )
      i_flit_buffer
      (
         .clk       (clk),
         .rst_n     (rst_n),
         .push      (in_valid[c]),
         .push_data (in_payload[c]),
         .pop       (pop[c]),
         .head      (head[c]),
         .not_empty (req[c]),
         .credit    (in_credit[c])
      );

      // arbiter needs to know where each head packet ends
      assign head_last[c] = head[c].last;
   end

   rr_arbiter i_rr_arbiter
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (req),
      .head_last (head_last),
      .can_send  (can_send),
      .pop       (pop),
      .send      (send),
      .grant_idx (grant_idx)
   );

   credit_tracker i_credit_tracker
   (
      .clk        (clk),
      .rst_n      (rst_n),
      .send       (send),
      .out_credit (out_credit),
      .can_send   (can_send)
   );

   // output stage, popped flit shows one cycle later
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         out_valid <= 1'b0;
      end
      else
      begin
         out_valid <= send;
      end
   end

   // payload register with the source stamped from the grant
   always_ff @(posedge clk)
   begin
      if (send)
      begin
         out_flit.src     <= grant_idx;
         out_flit.payload <= head[grant_idx];
      end
   end

endmodule

// ==== merge_tb.sv ====
/*
 * packet merger testbench
 * random packet senders with credit accounting, a downstream credit
 * model and per-channel reference queues checking order, packet
 * atomicity, credits, round-robin order and back-pressure
 */

`timescale 1ns/1ps

`include "merge_defines.svh"

module merge_tb;

   localparam int ports_lp      = `MERGE_PORTS;
   localparam int clk_period_lp = 4;
   localparam int rand_pkts_lp  = 12;
   localparam int fair_pkts_lp  = 10;
   localparam int bp_pkts_lp    = 4;
   // worst case flits over all tests, two random runs of up to 4 flits per packet
   localparam int max_flits_lp  =
      ports_lp * (2 * rand_pkts_lp * 4 + fair_pkts_lp + bp_pkts_lp * 4);
   localparam int watchdog_cycles_lp = max_flits_lp * 40;

   logic                 clk;
   logic                 rst_n;
   merge_pkg::port_vec_t in_valid;
   merge_pkg::payload_t  in_payload [ports_lp];
   merge_pkg::port_vec_t in_credit;
   logic                 out_valid;
   merge_pkg::flit_t     out_flit;
   logic                 out_credit;

   // reference model, expected payloads per channel in send order
   merge_pkg::payload_t exp_q [ports_lp][$];
   int snd_credits [ports_lp];
   int pkt_flits_left [ports_lp];
   int pkts_to_start [ports_lp];
   int accepted [ports_lp];
   int credits_back [ports_lp];

   // downstream receiver state
   int ds_pending;
   int ds_given;
   int out_total;
   int open_src;
   int prev_src;

   // test controls, changed on rising edges only
   int in_rate;       // percent chance a sender offers a flit
   int credit_rate;   // percent chance a held slot is freed
   bit credit_hold;
   bit single_flit;
   bit check_rr;

   int          errors;
   int          tests_run;
   int          tests_ok;
   logic [31:0] rand_state;

   packet_merger i_packet_merger
   (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_valid   (in_valid),
      .in_payload (in_payload),
      .in_credit  (in_credit),
      .out_valid  (out_valid),
      .out_flit   (out_flit),
      .out_credit (out_credit)
   );

   always
   begin
      #(clk_period_lp / 2) clk = ~clk;
   end

   // LCG step
   function automatic logic [31:0] next_rand();
      rand_state = rand_state * 32'd1664525 + 32'd1013904223;
      return rand_state;
   endfunction

   // low bits of an LCG are weak, take the upper ones
   function automatic int rand_below(input int n);
      logic [31:0] r;
      r = next_rand();
      return int'(r[31:8] % n);
   endfunction

   // first channel after from that still owes flits
   function automatic int next_backlogged(input int from);
      int c;
      for (int k = 1; k <= ports_lp; k++)
      begin
         c = (from + k) % ports_lp;
         if (exp_q[c].size() > 0)
         begin
            return c;
         end
      end
      return -1;
   endfunction

   task automatic observe_output();
      merge_pkg::payload_t expd;
      int s;
      int nxt;
      if (out_valid)
      begin
         s = int'(out_flit.src);
         out_total++;
         ds_pending++;
         if (out_total > `MERGE_OUT_CREDITS + ds_given)
         begin
            $display("flit %0d sent with only %0d downstream credits granted",
                     out_total, `MERGE_OUT_CREDITS + ds_given);
            errors++;
         end
         if (exp_q[s].size() == 0)
         begin
            $display("flit from channel %0d which had nothing outstanding", s);
            errors++;
         end
         else
         begin
            // src must be the next busy channel after the previous winner
            if (check_rr && prev_src >= 0)
            begin
               nxt = next_backlogged(prev_src);
               if (s != nxt)
               begin
                  $display("Mismatch out_flit.src (round robin): got %0h expected %0h", s, nxt);
                  errors++;
               end
            end
            expd = exp_q[s].pop_front();
            if (out_flit.payload.data !== expd.data)
            begin
               $display("Mismatch out_flit.payload.data ch %0d: got %h expected %h",
                        s, out_flit.payload.data, expd.data);
               errors++;
            end
            if (out_flit.payload.last !== expd.last)
            begin
               $display("Mismatch out_flit.payload.last ch %0d: got %h expected %h",
                        s, out_flit.payload.last, expd.last);
               errors++;
            end
         end
         // open packet pins the source until its last flit
         if (open_src >= 0 && s != open_src)
         begin
            $display("Mismatch out_flit.src (interleave): got %0h expected %0h", s, open_src);
            errors++;
         end
         open_src = out_flit.payload.last ? -1 : s;
         prev_src = s;
      end
   endtask

   task automatic collect_in_credits();
      for (int c = 0; c < ports_lp; c++)
      begin
         if (in_credit[c])
         begin
            credits_back[c]++;
            snd_credits[c]++;
            if (snd_credits[c] > `MERGE_BUF_DEPTH)
            begin
               $display("channel %0d got back more credits than it spent", c);
               errors++;
            end
         end
      end
   endtask

   task automatic drive_senders();
      merge_pkg::payload_t  p;
      merge_pkg::port_vec_t v;
      v = '0;
      for (int c = 0; c < ports_lp; c++)
      begin
         if (snd_credits[c] > 0 && (pkt_flits_left[c] > 0 || pkts_to_start[c] > 0) &&
             rand_below(100) < in_rate)
         begin
            // new packet of 1 to 4 flits
            if (pkt_flits_left[c] == 0)
            begin
               pkts_to_start[c]--;
               pkt_flits_left[c] = single_flit ? 1 : 1 + rand_below(4);
            end
            pkt_flits_left[c]--;
            p.data = `MERGE_DATA_W'(next_rand() >> 8);
            p.last = (pkt_flits_left[c] == 0);
            in_payload[c] = p;
            v[c] = 1'b1;
            snd_credits[c]--;
            accepted[c]++;
            exp_q[c].push_back(p);
         end
      end
      in_valid = v;
   endtask

   // receiver frees a slot now and then, one per cycle at most
   task automatic drive_out_credit();
      out_credit = 1'b0;
      if (!credit_hold && ds_pending > 0 && rand_below(100) < credit_rate)
      begin
         out_credit = 1'b1;
         ds_pending--;
         ds_given++;
      end
   endtask

   // outputs settled after the rising edge, sample them before driving
   always @(negedge clk)
   begin
      if (rst_n)
      begin
         observe_output();
         collect_in_credits();
         drive_senders();
         drive_out_credit();
      end
   end

   task automatic start_traffic(input int pkts, input int offer, input int ret,
                                input bit single);
      for (int c = 0; c < ports_lp; c++)
      begin
         pkts_to_start[c] = pkts;
      end
      in_rate     = offer;
      credit_rate = ret;
      single_flit = single;
   endtask

   task automatic wait_drained();
      bit busy;
      busy = 1'b1;
      while (busy)
      begin
         @(posedge clk);
         busy = (ds_pending != 0);
         for (int c = 0; c < ports_lp; c++)
         begin
            if (exp_q[c].size() != 0 || pkt_flits_left[c] != 0 || pkts_to_start[c] != 0)
            begin
               busy = 1'b1;
            end
         end
      end
      // last credits still have to land in both counters
      repeat (4) @(posedge clk);
   endtask

   task automatic finish_test(input string name, input int err_at_start);
      for (int c = 0; c < ports_lp; c++)
      begin
         if (credits_back[c] != accepted[c])
         begin
            $display("Mismatch in_credit[%0d] pulses: got %0h expected %0h",
                     c, credits_back[c], accepted[c]);
            errors++;
         end
      end
      tests_run++;
      if (errors == err_at_start)
      begin
         tests_ok++;
         $display("[%0t] %s: ok", $time, name);
      end
      else
      begin
         $display("[%0t] %s: %0d errors", $time, name, errors - err_at_start);
      end
   endtask

   initial
   begin
      int err0;
      int base;
      clk         = 1'b0;
      rst_n       = 1'b0;
      in_valid    = '0;
      out_credit  = 1'b0;
      rand_state  = 32'h4bec2fae;
      in_rate     = 0;
      credit_rate = 0;
      credit_hold = 1'b0;
      single_flit = 1'b0;
      check_rr    = 1'b0;
      ds_pending  = 0;
      ds_given    = 0;
      out_total   = 0;
      open_src    = -1;
      prev_src    = -1;
      errors      = 0;
      tests_run   = 0;
      tests_ok    = 0;
      for (int c = 0; c < ports_lp; c++)
      begin
         in_payload[c]     = '0;
         snd_credits[c]    = `MERGE_BUF_DEPTH;
         pkt_flits_left[c] = 0;
         pkts_to_start[c]  = 0;
         accepted[c]       = 0;
         credits_back[c]   = 0;
      end
      repeat (4) @(negedge clk);
      rst_n = 1'b1;

      // idle outputs after reset, nothing appears without input
      err0 = errors;
      if (out_valid !== 1'b0)
      begin
         $display("Mismatch out_valid after reset: got %h expected %h", out_valid, 1'b0);
         errors++;
      end
      if (in_credit !== '0)
      begin
         $display("Mismatch in_credit after reset: got %h expected %h", in_credit, 4'h0);
         errors++;
      end
      repeat (10) @(posedge clk);
      if (out_total != 0)
      begin
         $display("a flit came out before any input was offered");
         errors++;
      end
      finish_test("reset", err0);

      // mixed packets, slow then fast downstream
      err0 = errors;
      @(posedge clk);
      start_traffic(rand_pkts_lp, 60, 25, 1'b0);
      wait_drained();
      finish_test("random_slow_drain", err0);

      err0 = errors;
      @(posedge clk);
      start_traffic(rand_pkts_lp, 80, 90, 1'b0);
      wait_drained();
      finish_test("random_fast_drain", err0);

      // all buffers kept full with single flits
      err0 = errors;
      @(posedge clk);
      prev_src = -1;
      check_rr = 1'b1;
      start_traffic(fair_pkts_lp, 100, 100, 1'b1);
      wait_drained();
      check_rr = 1'b0;
      finish_test("round_robin", err0);

      // receiver holds every slot, only the initial credits get through
      err0 = errors;
      @(posedge clk);
      base = out_total;
      credit_hold = 1'b1;
      start_traffic(bp_pkts_lp, 70, 50, 1'b0);
      repeat (40) @(posedge clk);
      if (out_total - base != `MERGE_OUT_CREDITS)
      begin
         $display("Mismatch out_valid count under back-pressure: got %0h expected %0h",
                  out_total - base, `MERGE_OUT_CREDITS);
         errors++;
      end
      credit_hold = 1'b0;
      wait_drained();
      finish_test("back_pressure", err0);

      $display("%0d of %0d tests ok, %0d errors, %0d flits checked",
               tests_ok, tests_run, errors, out_total);
      if (errors == 0)
      begin
         $display("TEST PASSED");
      end
      else
      begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // bound on the whole run
   initial
   begin
      #(watchdog_cycles_lp * clk_period_lp);
      $display("watchdog expired before all tests finished");
      $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== src.f ====
+incdir+.
merge_pkg.sv
prefix_scan.sv
flit_buffer.sv
rr_arbiter.sv
credit_tracker.sv
packet_merger.sv
merge_tb.sv

// ==== Bender.yml ====
package:
  name: packet_merger

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - merge_pkg.sv
      - prefix_scan.sv
      - flit_buffer.sv
      - rr_arbiter.sv
      - credit_tracker.sv
      - packet_merger.sv
  - target: test
    include_dirs:
      - .
    files:
      - merge_tb.sv
